//--- hdl/cpuPkg.sv
package cpuPkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regAddr_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_LUI     // upper immediate passes through
    } aluOp_t;

    typedef enum logic {
        RES_ALU,
        RES_LOAD
    } resultSel_t;

    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_J     = 6'h02;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_ANDI  = 6'h0c;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_LUI   = 6'h0f;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;

    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

    localparam int    NUM_REGS   = 32;
    localparam int    DMEM_WORDS = 64;
    localparam int    DMEM_AW    = $clog2(DMEM_WORDS);
    localparam word_t RESET_PC   = 32'h0000_0000;

    typedef struct packed {
        logic  cyc;
        logic  stb;
        word_t adr;
    } wbFetchReq_t;

    typedef struct packed {
        logic  ack;
        word_t dat;
    } wbFetchRsp_t;

    typedef struct packed {
        word_t pc;
        word_t instr;
    } ifIdPayload_t;

    typedef struct packed {
        word_t      pc;
        word_t      opA;
        word_t      opB;
        word_t      storeData;
        aluOp_t     aluOp;
        logic       regWe;
        regAddr_t   regAddr;
        logic       memRead;
        logic       memWrite;
        resultSel_t resultSel;
    } idExPayload_t;

    typedef struct packed {
        word_t      pc;
        word_t      aluResult;
        word_t      storeData;
        logic       regWe;
        regAddr_t   regAddr;
        logic       memRead;
        logic       memWrite;
        resultSel_t resultSel;
    } exMemPayload_t;

    // pending register write seen from decode
    typedef struct packed {
        logic     valid;
        regAddr_t regAddr;
        word_t    data;
        logic     isLoad;
    } fwdSrc_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        logic     regWe;
        regAddr_t regAddr;
        word_t    data;
    } retireInfo_t;

endpackage

//--- hdl/pipeStageReg.sv
`timescale 1ns/10ps

module pipeStageReg #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    inValid,
    input  payloadT inData,
    output logic    outValid,
    output payloadT outData
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            outValid <= 1'b0;
        end else begin
            outValid <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        outData <= inData;  // bubble payload is don't care
    end

endmodule

//--- hdl/fetchStage.sv
`timescale 1ns/10ps

module fetchStage (
    input  logic                 clk,
    input  logic                 rst,
    output cpuPkg::wbFetchReq_t  fetchReq,
    input  cpuPkg::wbFetchRsp_t  fetchRsp,
    input  logic                 stall,
    input  logic                 redirect,
    input  cpuPkg::word_t        redirectPc,
    output logic                 ifValid,
    output cpuPkg::ifIdPayload_t ifData
);

    cpuPkg::word_t pc;         // address on the bus
    cpuPkg::word_t pendingPc;  // target waiting behind a dropped cycle
    logic          busActive;
    logic          discard;
    logic          take;

    assign take = fetchRsp.ack && !discard && !stall && !redirect;
    assign fetchReq = '{cyc: busActive, stb: busActive, adr: pc};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busActive <= 1'b0;
            discard   <= 1'b0;
            pc        <= cpuPkg::RESET_PC;
            pendingPc <= cpuPkg::RESET_PC;
            ifValid   <= 1'b0;
        end else begin
            busActive <= 1'b1;  // fetch never idles after reset
            if (discard) begin
                if (fetchRsp.ack) begin
                    discard <= 1'b0;
                    pc      <= pendingPc;
                end
            end else if (redirect && !fetchRsp.ack) begin
                discard   <= 1'b1;  // finish the old cycle first
                pendingPc <= redirectPc;
            end else if (redirect) begin
                pc <= redirectPc;
            end else if (take) begin
                pc <= pc + 32'd4;
            end

            if (redirect) begin
                ifValid <= 1'b0;
            end else if (!stall) begin
                ifValid <= take;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            ifData <= '{pc: pc, instr: fetchRsp.dat};
        end
    end

    adrStable: assert property (@(posedge clk) disable iff (rst)
        fetchReq.stb && !fetchRsp.ack |=> $stable(fetchReq.adr));

endmodule

//--- hdl/regFile.sv
`timescale 1ns/10ps

module regFile (
    input  logic                clk,
    input  logic                rst,
    input  cpuPkg::regAddr_t    raddrA,
    input  cpuPkg::regAddr_t    raddrB,
    output cpuPkg::word_t       rdataA,
    output cpuPkg::word_t       rdataB,
    input  cpuPkg::retireInfo_t wr
);

    cpuPkg::word_t regs [cpuPkg::NUM_REGS];
    logic          wrEn;

    assign wrEn = wr.valid && wr.regWe && wr.regAddr != '0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < cpuPkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wr.regAddr] <= wr.data;
        end
    end

    // same-cycle write shows up on the read ports
    assign rdataA = (raddrA == '0) ? '0 :
                    (wrEn && wr.regAddr == raddrA) ? wr.data : regs[raddrA];
    assign rdataB = (raddrB == '0) ? '0 :
                    (wrEn && wr.regAddr == raddrB) ? wr.data : regs[raddrB];

endmodule

//--- hdl/decodeStage.sv
`timescale 1ns/10ps

module decodeStage (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 ifValid,
    input  cpuPkg::ifIdPayload_t ifData,
    input  cpuPkg::fwdSrc_t      exFwd,
    input  cpuPkg::fwdSrc_t      memFwd,
    input  cpuPkg::retireInfo_t  wbWrite,
    output logic                 stall,
    output logic                 redirect,
    output cpuPkg::word_t        redirectPc,
    output logic                 idValid,
    output cpuPkg::idExPayload_t idData
);

    logic [5:0]        opcode;
    logic [5:0]        funct;
    cpuPkg::regAddr_t  rs;
    cpuPkg::regAddr_t  rt;
    cpuPkg::regAddr_t  destAddr;
    cpuPkg::word_t     rfA;
    cpuPkg::word_t     rfB;
    cpuPkg::word_t     rsVal;
    cpuPkg::word_t     rtVal;
    cpuPkg::word_t     immExt;
    cpuPkg::word_t     pcPlus4;
    cpuPkg::aluOp_t    aluOp;
    logic              useImm;
    logic              zeroExt;
    logic              writes;
    logic              destRd;
    logic              memRead;
    logic              memWrite;
    logic              taken;

    function automatic cpuPkg::word_t fwdPick(cpuPkg::regAddr_t a, cpuPkg::word_t rf,
                                              cpuPkg::fwdSrc_t ex, cpuPkg::fwdSrc_t mem);
        if (ex.valid && ex.regAddr == a)
            return ex.data;  // youngest producer wins
        if (mem.valid && mem.regAddr == a)
            return mem.data;
        return rf;
    endfunction

    assign opcode   = ifData.instr[31:26];
    assign rs       = ifData.instr[25:21];
    assign rt       = ifData.instr[20:16];
    assign funct    = ifData.instr[5:0];
    assign destAddr = destRd ? ifData.instr[15:11] : rt;
    assign pcPlus4  = ifData.pc + 32'd4;
    assign immExt   = zeroExt ? {16'b0, ifData.instr[15:0]}
                              : {{16{ifData.instr[15]}}, ifData.instr[15:0]};

    regFile regFile_inst (
        .clk    (clk),
        .rst    (rst),
        .raddrA (rs),
        .raddrB (rt),
        .rdataA (rfA),
        .rdataB (rfB),
        .wr     (wbWrite)
    );

    assign rsVal = fwdPick(rs, rfA, exFwd, memFwd);
    assign rtVal = fwdPick(rt, rfB, exFwd, memFwd);

    always_comb begin
        aluOp    = cpuPkg::ALU_ADD;
        useImm   = 1'b1;
        zeroExt  = 1'b0;
        writes   = 1'b1;
        destRd   = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        taken    = 1'b0;
        case (opcode)
            cpuPkg::OP_RTYPE: begin
                useImm = 1'b0;
                destRd = 1'b1;
                case (funct)
                    cpuPkg::FN_ADDU: aluOp = cpuPkg::ALU_ADD;
                    cpuPkg::FN_SUBU: aluOp = cpuPkg::ALU_SUB;
                    cpuPkg::FN_AND:  aluOp = cpuPkg::ALU_AND;
                    cpuPkg::FN_OR:   aluOp = cpuPkg::ALU_OR;
                    cpuPkg::FN_XOR:  aluOp = cpuPkg::ALU_XOR;
                    cpuPkg::FN_SLT:  aluOp = cpuPkg::ALU_SLT;
                    cpuPkg::FN_SLTU: aluOp = cpuPkg::ALU_SLTU;
                    default:         writes = 1'b0;
                endcase
            end
            cpuPkg::OP_ADDIU: aluOp = cpuPkg::ALU_ADD;
            cpuPkg::OP_ANDI: begin
                aluOp   = cpuPkg::ALU_AND;
                zeroExt = 1'b1;
            end
            cpuPkg::OP_ORI: begin
                aluOp   = cpuPkg::ALU_OR;
                zeroExt = 1'b1;
            end
            cpuPkg::OP_LUI: aluOp = cpuPkg::ALU_LUI;
            cpuPkg::OP_LW:  memRead = 1'b1;
            cpuPkg::OP_SW: begin
                memWrite = 1'b1;
                writes   = 1'b0;
            end
            cpuPkg::OP_BEQ: begin
                writes = 1'b0;
                taken  = rsVal == rtVal;
            end
            cpuPkg::OP_BNE: begin
                writes = 1'b0;
                taken  = rsVal != rtVal;
            end
            cpuPkg::OP_J: begin
                writes = 1'b0;
                taken  = 1'b1;
            end
            default: writes = 1'b0;  // retires as a no-op
        endcase
    end

    // load in execute can't forward yet
    assign stall = ifValid && exFwd.valid && exFwd.isLoad
                   && (exFwd.regAddr == rs || exFwd.regAddr == rt);
    assign idValid    = ifValid && !stall;
    assign redirect   = idValid && taken;
    assign redirectPc = (opcode == cpuPkg::OP_J)
                      ? {pcPlus4[31:28], ifData.instr[25:0], 2'b00}
                      : pcPlus4 + {immExt[29:0], 2'b00};

    assign idData = '{
        pc:        ifData.pc,
        opA:       rsVal,
        opB:       useImm ? immExt : rtVal,
        storeData: rtVal,
        aluOp:     aluOp,
        regWe:     writes && destAddr != '0,
        regAddr:   destAddr,
        memRead:   memRead,
        memWrite:  memWrite,
        resultSel: memRead ? cpuPkg::RES_LOAD : cpuPkg::RES_ALU
    };

    noRedirectInStall: assert property (@(posedge clk) disable iff (rst)
        !(redirect && stall));

endmodule

//--- hdl/executeStage.sv
`timescale 1ns/10ps

module executeStage (
    input  logic                  exValid,
    input  cpuPkg::idExPayload_t  exData,
    output cpuPkg::exMemPayload_t exOut,
    output cpuPkg::fwdSrc_t       exFwd
);

    cpuPkg::word_t a;
    cpuPkg::word_t b;
    cpuPkg::word_t aluResult;

    assign a = exData.opA;
    assign b = exData.opB;

    always_comb begin
        case (exData.aluOp)
            cpuPkg::ALU_ADD:  aluResult = a + b;
            cpuPkg::ALU_SUB:  aluResult = a - b;
            cpuPkg::ALU_AND:  aluResult = a & b;
            cpuPkg::ALU_OR:   aluResult = a | b;
            cpuPkg::ALU_XOR:  aluResult = a ^ b;
            cpuPkg::ALU_SLT:  aluResult = {31'b0, $signed(a) < $signed(b)};
            cpuPkg::ALU_SLTU: aluResult = {31'b0, a < b};
            cpuPkg::ALU_LUI:  aluResult = {b[15:0], 16'b0};
            default:          aluResult = a + b;
        endcase
    end

    assign exOut = '{
        pc:        exData.pc,
        aluResult: aluResult,
        storeData: exData.storeData,
        regWe:     exData.regWe,
        regAddr:   exData.regAddr,
        memRead:   exData.memRead,
        memWrite:  exData.memWrite,
        resultSel: exData.resultSel
    };

    // for a load, data is only the address
    assign exFwd = '{
        valid:   exValid && exData.regWe,
        regAddr: exData.regAddr,
        data:    aluResult,
        isLoad:  exData.memRead
    };

endmodule

//--- hdl/memoryStage.sv
`timescale 1ns/10ps

module memoryStage (
    input  logic                  clk,
    input  logic                  memValid,
    input  cpuPkg::exMemPayload_t memData,
    output cpuPkg::retireInfo_t   wbOut,
    output cpuPkg::fwdSrc_t       memFwd
);

    cpuPkg::word_t              dmem [cpuPkg::DMEM_WORDS];
    logic [cpuPkg::DMEM_AW-1:0] wordIdx;
    cpuPkg::word_t              loadData;
    cpuPkg::word_t              result;

    assign wordIdx  = memData.aluResult[cpuPkg::DMEM_AW+1:2];
    assign loadData = dmem[wordIdx];  // async read
    assign result   = (memData.resultSel == cpuPkg::RES_LOAD) ? loadData : memData.aluResult;

    always_ff @(posedge clk) begin
        if (memValid && memData.memWrite) begin
            dmem[wordIdx] <= memData.storeData;
        end
    end

    assign wbOut = '{
        valid:   memValid,
        pc:      memData.pc,
        regWe:   memData.regWe,
        regAddr: memData.regAddr,
        data:    result
    };

    assign memFwd = '{
        valid:   memValid && memData.regWe,
        regAddr: memData.regAddr,
        data:    result,
        isLoad:  memData.memRead
    };

    addrInRange: assert property (@(posedge clk)
        memValid && (memData.memRead || memData.memWrite) |->
            memData.aluResult[1:0] == 2'b00
            && memData.aluResult < cpuPkg::DMEM_WORDS * 4);

endmodule

//--- hdl/cpuPipe.sv
`timescale 1ns/10ps

module cpuPipe (
    input  logic                clk,
    input  logic                rst,
    output cpuPkg::wbFetchReq_t fetchReq,
    input  cpuPkg::wbFetchRsp_t fetchRsp,
    output cpuPkg::retireInfo_t retire
);

    logic                  stall;
    logic                  redirect;
    cpuPkg::word_t         redirectPc;
    logic                  ifValid;
    cpuPkg::ifIdPayload_t  ifData;
    logic                  idValid;
    cpuPkg::idExPayload_t  idData;
    logic                  exValid;
    cpuPkg::idExPayload_t  exData;
    cpuPkg::exMemPayload_t exOut;
    cpuPkg::fwdSrc_t       exFwd;
    logic                  memValid;
    cpuPkg::exMemPayload_t memData;
    cpuPkg::retireInfo_t   wbOut;
    cpuPkg::fwdSrc_t       memFwd;
    logic                  wbValid;
    cpuPkg::retireInfo_t   wbData;

    fetchStage fetchStage_inst (
        .clk(clk), .rst(rst), .fetchReq(fetchReq), .fetchRsp(fetchRsp),
        .stall(stall), .redirect(redirect), .redirectPc(redirectPc),
        .ifValid(ifValid), .ifData(ifData)
    );

    decodeStage decodeStage_inst (
        .clk(clk), .rst(rst), .ifValid(ifValid), .ifData(ifData),
        .exFwd(exFwd), .memFwd(memFwd), .wbWrite(retire),
        .stall(stall), .redirect(redirect), .redirectPc(redirectPc),
        .idValid(idValid), .idData(idData)
    );

    pipeStageReg #(.payloadT(cpuPkg::idExPayload_t)) idExReg_inst (
        .clk(clk), .rst(rst), .inValid(idValid), .inData(idData),
        .outValid(exValid), .outData(exData)
    );

    executeStage executeStage_inst (
        .exValid(exValid), .exData(exData), .exOut(exOut), .exFwd(exFwd)
    );

    pipeStageReg #(.payloadT(cpuPkg::exMemPayload_t)) exMemReg_inst (
        .clk(clk), .rst(rst), .inValid(exValid), .inData(exOut),
        .outValid(memValid), .outData(memData)
    );

    memoryStage memoryStage_inst (
        .clk(clk), .memValid(memValid), .memData(memData),
        .wbOut(wbOut), .memFwd(memFwd)
    );

    pipeStageReg #(.payloadT(cpuPkg::retireInfo_t)) memWbReg_inst (
        .clk(clk), .rst(rst), .inValid(memValid), .inData(wbOut),
        .outValid(wbValid), .outData(wbData)
    );

    always_comb begin
        retire       = wbData;
        retire.valid = wbValid;  // reset-cleared copy of the stage valid
    end

endmodule

//--- testbench/isaModel.svh
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

localparam int PROG_WORDS = 64;

cpuPkg::word_t       prog [PROG_WORDS];
cpuPkg::retireInfo_t expQ [$];  // expected retire stream, oldest first

function automatic cpuPkg::word_t encodeR(int rs, int rt, int rd, logic [5:0] fn);
    return {cpuPkg::OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'b0, fn};
endfunction

function automatic cpuPkg::word_t encodeI(logic [5:0] op, int rs, int rt, logic [15:0] imm);
    return {op, 5'(rs), 5'(rt), imm};
endfunction

function automatic cpuPkg::word_t encodeJ(int wordIdx);
    return {cpuPkg::OP_J, 26'(wordIdx)};
endfunction

function automatic cpuPkg::word_t refAlu(logic [5:0] fn, cpuPkg::word_t a, cpuPkg::word_t b);
    case (fn)
        cpuPkg::FN_ADDU: return a + b;
        cpuPkg::FN_SUBU: return a - b;
        cpuPkg::FN_AND:  return a & b;
        cpuPkg::FN_OR:   return a | b;
        cpuPkg::FN_XOR:  return a ^ b;
        cpuPkg::FN_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        default:         return (a < b) ? 32'd1 : 32'd0;  // sltu
    endcase
endfunction

// builds the program and its expected retire stream in one pass
task automatic buildProgram(int records);
    logic [5:0]    rFuncts [7] = '{cpuPkg::FN_ADDU, cpuPkg::FN_SUBU, cpuPkg::FN_AND,
                                   cpuPkg::FN_OR, cpuPkg::FN_XOR, cpuPkg::FN_SLT,
                                   cpuPkg::FN_SLTU};
    cpuPkg::word_t regs [8];
    cpuPkg::word_t mem [cpuPkg::DMEM_WORDS];
    int            stored [$];
    int            nextIdx;
    int            prevDst;
    int            kind;
    int            rs;
    int            rt;
    int            dst;
    int            word;
    int            tgt;
    logic [15:0]   imm;
    cpuPkg::word_t ins;
    cpuPkg::word_t res;
    logic          we;
    logic          taken;
    regs = '{default: '0};
    nextIdx = 0;
    prevDst = 0;
    for (int i = 0; i < PROG_WORDS - 1; i++) begin
        kind = $urandom_range(15);
        rs   = $urandom_range(7, 1);
        rt   = $urandom_range(7, 1);
        dst  = $urandom_range(7, 1);
        imm  = 16'($urandom);
        word = $urandom_range(cpuPkg::DMEM_WORDS - 1);
        tgt  = i + 2 + $urandom_range(2);
        if (prevDst != 0 && $urandom_range(3) != 0) begin
            rs = prevDst;  // mostly consume the previous result
        end
        if (tgt > PROG_WORDS - 1) tgt = PROG_WORDS - 1;
        if (kind == 12 && stored.size() == 0) kind = 11;  // nothing stored yet
        we    = 1'b1;
        taken = 1'b0;
        res   = '0;
        case (kind)
            7: begin
                ins = encodeI(cpuPkg::OP_ADDIU, rs, dst, imm);
                res = refAlu(cpuPkg::FN_ADDU, regs[rs], {{16{imm[15]}}, imm});
            end
            8: begin
                ins = encodeI(cpuPkg::OP_ANDI, rs, dst, imm);
                res = refAlu(cpuPkg::FN_AND, regs[rs], {16'b0, imm});
            end
            9: begin
                ins = encodeI(cpuPkg::OP_ORI, rs, dst, imm);
                res = refAlu(cpuPkg::FN_OR, regs[rs], {16'b0, imm});
            end
            10: begin
                ins = encodeI(cpuPkg::OP_LUI, 0, dst, imm);
                res = {imm, 16'b0};
            end
            11: begin
                ins = encodeI(cpuPkg::OP_SW, 0, rt, 16'(word * 4));
                we  = 1'b0;
            end
            12: begin
                word = stored[$urandom_range(stored.size() - 1)];
                ins  = encodeI(cpuPkg::OP_LW, 0, dst, 16'(word * 4));
                res  = mem[word];
            end
            13, 14: begin
                ins   = encodeI((kind == 13) ? cpuPkg::OP_BEQ : cpuPkg::OP_BNE, rs, rt,
                                16'(tgt - i - 1));
                we    = 1'b0;
                taken = (regs[rs] == regs[rt]) == (kind == 13);
            end
            15: begin
                ins   = encodeJ(tgt);
                we    = 1'b0;
                taken = 1'b1;
            end
            default: begin
                ins = encodeR(rs, rt, dst, rFuncts[kind]);
                res = refAlu(rFuncts[kind], regs[rs], regs[rt]);
            end
        endcase
        prog[i] = ins;
        prevDst = we ? dst : 0;
        if (i == nextIdx) begin  // on the executed path
            if (we) regs[dst] = res;
            if (kind == 11) begin
                mem[word] = regs[rt];
                stored.push_back(word);
            end
            expQ.push_back('{valid: 1'b1, pc: 32'(i * 4), regWe: we, regAddr: 5'(dst),
                             data: res});
            nextIdx = taken ? tgt : i + 1;
        end
    end
    prog[PROG_WORDS - 1] = encodeJ(PROG_WORDS - 1);  // parks the core
    while (expQ.size() <= records) begin
        expQ.push_back('{valid: 1'b1, pc: 32'((PROG_WORDS - 1) * 4), regWe: 1'b0,
                         regAddr: '0, data: '0});
    end
endtask

`endif

//--- testbench/pipeCpuTb.sv
`timescale 1ns/10ps

module pipeCpuTb;

    localparam int CLK_PERIOD    = 40;
    localparam int RESET_CYCLES  = 8;
    localparam int MAX_WAIT      = 3;
    localparam int RETIRE_TARGET = 200;
    localparam int WATCHDOG_NS   = RETIRE_TARGET * (MAX_WAIT + 1 + 3) * CLK_PERIOD
                                 + RESET_CYCLES * CLK_PERIOD;

    logic                clk;
    logic                rst;
    cpuPkg::wbFetchReq_t fetchReq;
    cpuPkg::wbFetchRsp_t fetchRsp;
    cpuPkg::retireInfo_t retire;
    cpuPkg::retireInfo_t expRec;    // record the next retire must match
    cpuPkg::word_t       lastAdr;
    int                  retired = 0;
    int                  waitLeft = 0;
    logic                armed = 1'b0;

    `include "isaModel.svh"

    cpuPipe cpuPipe_inst (
        .clk      (clk),
        .rst      (rst),
        .fetchReq (fetchReq),
        .fetchRsp (fetchRsp),
        .retire   (retire)
    );

    task automatic failRun(string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic reportMismatch(string sig, cpuPkg::word_t expVal, cpuPkg::word_t actVal);
        failRun($sformatf("[ERROR] %0t %s expected %h actual %h", $time, sig, expVal, actVal));
    endtask

    function automatic cpuPkg::word_t fetchWord(cpuPkg::word_t adr);
        return (adr[31:2] < PROG_WORDS) ? prog[adr[31:2]] : '0;
    endfunction

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst      = 1'b1;
        fetchRsp = '0;
        void'($urandom(28058));
        buildProgram(RETIRE_TARGET);
        expRec = expQ.pop_front();
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
    end

    initial begin
        #(WATCHDOG_NS);
        failRun("watchdog expired before all instructions retired");
    end

    // instruction memory slave, 0 to MAX_WAIT wait states per request
    always @(negedge clk) begin
        if (rst || !fetchReq.stb) begin
            armed        = 1'b0;
            fetchRsp.ack = 1'b0;
        end else begin
            if (!armed) begin
                armed    = 1'b1;
                waitLeft = $urandom_range(MAX_WAIT);
            end
            if (waitLeft == 0) begin
                fetchRsp.ack = 1'b1;
                fetchRsp.dat = fetchWord(fetchReq.adr);
                armed        = 1'b0;
            end else begin
                fetchRsp.ack = 1'b0;
                waitLeft--;
            end
        end
    end

    always @(posedge clk) begin
        lastAdr <= fetchReq.adr;
        if (!rst && retire.valid) begin
            retired <= retired + 1;
            expRec  <= expQ.pop_front();
        end
    end

    always @(negedge clk) begin
        if (retired >= RETIRE_TARGET) begin
            $display("Simulation passed");
            $finish;
        end
    end

    busQuietInReset: assert property (@(posedge clk)
        (rst || $fell(rst)) |-> !fetchReq.cyc && !fetchReq.stb && !retire.valid)
        else failRun("fetch bus or retire port active during or right after reset");

    adrHeldInWait: assert property (@(posedge clk) disable iff (rst)
        fetchReq.stb && !fetchRsp.ack |=> $stable(fetchReq.adr))
        else reportMismatch("fetchReq.adr", $sampled(lastAdr), $sampled(fetchReq.adr));

    retirePc: assert property (@(posedge clk) disable iff (rst)
        retire.valid |-> retire.pc == expRec.pc)
        else reportMismatch("retire.pc", $sampled(expRec.pc), $sampled(retire.pc));

    retireRegWe: assert property (@(posedge clk) disable iff (rst)
        retire.valid |-> retire.regWe == expRec.regWe)
        else reportMismatch("retire.regWe", 32'($sampled(expRec.regWe)),
                            32'($sampled(retire.regWe)));

    // address and data only mean something for a register write
    retireRegAddr: assert property (@(posedge clk) disable iff (rst)
        retire.valid && expRec.regWe |-> retire.regAddr == expRec.regAddr)
        else reportMismatch("retire.regAddr", 32'($sampled(expRec.regAddr)),
                            32'($sampled(retire.regAddr)));

    retireData: assert property (@(posedge clk) disable iff (rst)
        retire.valid && expRec.regWe |-> retire.data == expRec.data)
        else reportMismatch("retire.data", $sampled(expRec.data), $sampled(retire.data));

endmodule

//--- compile.f
+incdir+testbench
hdl/cpuPkg.sv
hdl/pipeStageReg.sv
hdl/fetchStage.sv
hdl/regFile.sv
hdl/decodeStage.sv
hdl/executeStage.sv
hdl/memoryStage.sv
hdl/cpuPipe.sv
testbench/pipeCpuTb.sv
